//--- fp_pkg.sv
package fp_pkg;

	// ==============================
	// Word format
	// ==============================
	// Sign, 8-bit biased exponent, 18-bit fraction with hidden one
	localparam int FP_W   = 27;
	localparam int EXP_W  = 8;
	localparam int FRAC_W = 18;
	localparam int INT_W  = 16;

	// Bias of 127 means exponent 127 is 2^0
	localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;

	// Largest integer magnitude from float to integer
	localparam logic [INT_W-1:0] INT_MAX = 16'h7FFF;

	// Initial guess constant for the inverse square root
	localparam logic [FP_W-1:0] INV_SQRT_MAGIC = 27'd49920718;
	// 1.5 in this word format
	localparam logic [FP_W-1:0] THREE_HALVES   = 27'd33423360;

	// ==============================
	// Pipeline depths
	// ==============================
	localparam int ADD_LATENCY      = 2;
	localparam int INV_SQRT_LATENCY = 5;
	// From the in_valid sample edge to out_valid
	localparam int UNIT_LATENCY     = 6;

	// ==============================
	// Operations and word views
	// ==============================
	localparam int OP_W = 3;

	typedef enum logic [OP_W-1:0] {
		OP_ADD       = 3'd0,
		OP_SUB       = 3'd1,
		OP_MUL       = 3'd2,
		OP_INV_SQRT  = 3'd3,
		OP_INT_TO_FP = 3'd4,
		OP_FP_TO_INT = 3'd5,
		OP_CMP_GE    = 3'd6,
		OP_ABS       = 3'd7
	} fp_op_e;

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [FRAC_W-1:0] frac;
	} fp_fields_s;

	// Fields for arithmetic, raw bits for the integer trick in inv sqrt
	typedef union packed {
		fp_fields_s        fields;
		logic [FP_W-1:0]   raw;
	} fp_word_u;

endpackage

//--- fp_mul.sv
`timescale 1ns/1ps

module fp_mul (
	input  fp_pkg::fp_word_u a,
	input  fp_pkg::fp_word_u b,
	output fp_pkg::fp_word_u prod
);
	import fp_pkg::*;

	// Mantissas with hidden one, LSB of stored fraction dropped
	logic [FRAC_W-1:0]   a_man;
	logic [FRAC_W-1:0]   b_man;
	logic [2*FRAC_W-1:0] pre_frac;
	logic [EXP_W:0]      pre_exp;
	logic [EXP_W:0]      norm_exp;
	logic [FRAC_W-1:0]   prod_frac;
	logic                prod_sign;
	logic                underflow;
	logic                any_zero;

	assign a_man = {1'b1, a.fields.frac[FRAC_W-1:1]};
	assign b_man = {1'b1, b.fields.frac[FRAC_W-1:1]};

	// Sign of product
	assign prod_sign = a.fields.sign ^ b.fields.sign;

	// Full product, low bits truncated later
	assign pre_frac = a_man * b_man;

	// Biased exponent sum, one extra bit
	assign pre_exp = a.fields.exp + b.fields.exp;

	// Product in [1,4), normalize by at most one place
	assign norm_exp = pre_frac[2*FRAC_W-1] ? (pre_exp - EXP_BIAS + 9'd1) :
		(pre_exp - EXP_BIAS);
	// Top product bit set means hidden one sits one place higher
	assign prod_frac = pre_frac[2*FRAC_W-1] ? pre_frac[2*FRAC_W-2:FRAC_W-1] :
		pre_frac[2*FRAC_W-3:FRAC_W-2];

	// Exponent sum too small for a biased result
	assign underflow = pre_exp < 9'h80;
	// Zero exponent encodes zero
	assign any_zero = (a.fields.exp == '0) || (b.fields.exp == '0);

	assign prod = (underflow || any_zero) ? '0 :
		{prod_sign, norm_exp[EXP_W-1:0], prod_frac};

endmodule

//--- fp_add.sv
`timescale 1ns/1ps

module fp_add (
	input  logic             iCLK,
	input  logic             arst_n,
	input  fp_pkg::fp_word_u a,
	input  fp_pkg::fp_word_u b,
	output fp_pkg::fp_word_u sum
);
	import fp_pkg::*;

	// ==============================
	// Stage 1 alignment
	// ==============================
	logic [FRAC_W-1:0]   a_man;
	logic [FRAC_W-1:0]   b_man;
	logic [EXP_W-1:0]    diff_a;
	logic [EXP_W-1:0]    diff_b;
	logic [EXP_W-1:0]    larger_exp;
	logic                a_larger;
	logic [2*FRAC_W:0]   a_shift;
	logic [2*FRAC_W:0]   b_shift;
	logic [2*FRAC_W:0]   pre_sum;

	// Stage 1 to 2 registers
	logic [2*FRAC_W:0]   buf_pre_sum;
	logic [EXP_W-1:0]    buf_larger_exp;
	logic                buf_a_zero;
	logic                buf_b_zero;
	fp_word_u            buf_a;
	fp_word_u            buf_b;
	logic                buf_sign;
	// Set once stage 1 holds real data
	logic                stage1_loaded;

	// Stage 2 normalization
	logic [EXP_W-1:0]    shft_amt;
	logic [3*FRAC_W-1:0] norm_shift;
	logic [3*FRAC_W-1:0] uflow_shift;
	logic [FRAC_W-1:0]   sum_frac;
	logic [EXP_W-1:0]    sum_exp;
	logic                underflow;

	assign a_man = {1'b1, a.fields.frac[FRAC_W-1:1]};
	assign b_man = {1'b1, b.fields.frac[FRAC_W-1:1]};

	// Exponent gaps for either ordering
	assign diff_a = b.fields.exp - a.fields.exp;
	assign diff_b = a.fields.exp - b.fields.exp;
	assign larger_exp = (b.fields.exp > a.fields.exp) ? b.fields.exp : a.fields.exp;

	// Magnitude order on truncated mantissas
	assign a_larger = (a.fields.exp > b.fields.exp) ||
		((a.fields.exp == b.fields.exp) && (a_man > b_man));

	// Smaller operand shifted right, lost entirely past 35 places
	assign a_shift = a_larger ? {1'b0, a_man, {FRAC_W{1'b0}}} :
		(diff_a > 8'd35) ? '0 : ({1'b0, a_man, {FRAC_W{1'b0}}} >> diff_a);
	assign b_shift = !a_larger ? {1'b0, b_man, {FRAC_W{1'b0}}} :
		(diff_b > 8'd35) ? '0 : ({1'b0, b_man, {FRAC_W{1'b0}}} >> diff_b);

	// Unlike signs subtract, larger minus smaller
	assign pre_sum = ((a.fields.sign ^ b.fields.sign) && a_larger) ? a_shift - b_shift :
		((a.fields.sign ^ b.fields.sign) && !a_larger) ? b_shift - a_shift :
		a_shift + b_shift;

	always_ff @(posedge iCLK) begin
		buf_pre_sum    <= pre_sum;
		buf_larger_exp <= larger_exp;
		buf_a_zero     <= (a.fields.exp == '0);
		buf_b_zero     <= (b.fields.exp == '0);
		buf_a          <= a;
		buf_b          <= b;
		buf_sign       <= a_larger ? a.fields.sign : b.fields.sign;
	end

	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			stage1_loaded <= 1'b0;
		end else begin
			stage1_loaded <= 1'b1;
		end
	end

	// ==============================
	// Stage 2 normalization
	// ==============================
	// Distance of the leading one from bit 36, 37 when empty
	always_comb begin
		shft_amt = 8'd37;
		for (int i = 0; i <= 2*FRAC_W; i++) begin
			if (buf_pre_sum[i]) begin
				shft_amt = 8'(2*FRAC_W - i);
			end
		end
	end

	// Extra place drops the hidden one
	assign norm_shift  = {buf_pre_sum, {(FRAC_W-1){1'b0}}} << (shft_amt + 8'd1);
	assign uflow_shift = {buf_pre_sum, {(FRAC_W-1){1'b0}}} << shft_amt;
	assign sum_frac    = norm_shift[3*FRAC_W-1:2*FRAC_W];
	assign sum_exp     = buf_larger_exp - shft_amt + 8'd1;

	// No leading one left after the shift
	assign underflow = !uflow_shift[3*FRAC_W-1];

	// Zero operand passes the other through
	always_ff @(posedge iCLK) begin
		sum <= (buf_a_zero && buf_b_zero) ? '0 :
			buf_a_zero ? buf_b :
			buf_b_zero ? buf_a :
			underflow ? '0 :
			(buf_pre_sum == '0) ? '0 :
			{buf_sign, sum_exp, sum_frac};
	end

	// Two zero operands always give a zero word
	a_both_zero: assert property (@(posedge iCLK) disable iff (!arst_n)
		stage1_loaded && buf_a_zero && buf_b_zero |=> sum.raw == '0);

endmodule

//--- fp_inv_sqrt.sv
`timescale 1ns/1ps

module fp_inv_sqrt (
	input  logic             iCLK,
	input  logic             arst_n,
	input  fp_pkg::fp_word_u a,
	output fp_pkg::fp_word_u inv_sqrt
);
	import fp_pkg::*;

	// Stage 1 guess and half operand
	fp_word_u y_1;
	fp_word_u half_a_1;
	fp_word_u y_sq;
	// Stage 2
	fp_word_u half_a_2;
	fp_word_u mult_2_in;
	fp_word_u half_a_y2;
	// Stage 3 into the adder
	fp_word_u add_3_in;
	fp_word_u neg_term;
	fp_word_u correction;
	// Stage 5
	fp_word_u mult_5_in;
	// Guess carried alongside to the last multiply
	fp_word_u y_dly [INV_SQRT_LATENCY];

	// Integer trick on the raw bits
	assign y_1 = INV_SQRT_MAGIC - (a.raw >> 1);
	// Halving by exponent decrement
	assign half_a_1 = {a.fields.sign, a.fields.exp - 8'd1, a.fields.frac};

	// y squared
	fp_mul s1_mul (
		.a    (y_1),
		.b    (y_1),
		.prod (y_sq)
	);

	// Half a times y squared
	fp_mul s2_mul (
		.a    (half_a_2),
		.b    (mult_2_in),
		.prod (half_a_y2)
	);

	// 1.5 minus the term, two cycles
	assign neg_term = {~add_3_in.fields.sign, add_3_in.fields.exp, add_3_in.fields.frac};
	fp_add s3_add (
		.iCLK   (iCLK),
		.arst_n (arst_n),
		.a      (neg_term),
		.b      (THREE_HALVES),
		.sum    (correction)
	);

	// One Newton step result
	fp_mul s5_mul (
		.a    (y_dly[INV_SQRT_LATENCY-1]),
		.b    (mult_5_in),
		.prod (inv_sqrt)
	);

	always_ff @(posedge iCLK) begin
		y_dly[0] <= y_1;
		for (int i = 1; i < INV_SQRT_LATENCY; i++) begin
			y_dly[i] <= y_dly[i-1];
		end
		mult_2_in <= y_sq;
		half_a_2  <= half_a_1;
		add_3_in  <= half_a_y2;
		// Adder result lines up with the fifth guess copy
		mult_5_in <= correction;
	end

endmodule

//--- fp_int_convert.sv
`timescale 1ns/1ps

module fp_int_convert (
	input  logic signed [fp_pkg::INT_W-1:0] int_in,
	input  fp_pkg::fp_word_u                fp_in,
	output fp_pkg::fp_word_u                fp_out,
	output logic signed [fp_pkg::INT_W-1:0] int_out
);
	import fp_pkg::*;

	// ==============================
	// Integer to float
	// ==============================
	logic [INT_W-1:0]        abs_int;
	logic [EXP_W-1:0]        shft_amt;
	logic [INT_W+FRAC_W-1:0] int_shift;
	logic [EXP_W-1:0]        int_exp;
	logic                    int_sign;

	// Float to integer
	logic [INT_W+FRAC_W-1:0] fp_shift;
	logic [INT_W-1:0]        int_mag;

	assign int_sign = int_in < 0;
	// -32768 still lands with bit 15 set
	assign abs_int = int_sign ? -int_in : int_in;

	// Shift that moves the leading one to bit 18
	always_comb begin
		shft_amt = 8'(FRAC_W + 1);
		for (int i = 0; i < INT_W; i++) begin
			if (abs_int[i]) begin
				shft_amt = 8'(FRAC_W - i);
			end
		end
	end

	// 145 minus shift
	assign int_exp   = EXP_BIAS + 8'(FRAC_W) - shft_amt;
	assign int_shift = {{FRAC_W{1'b0}}, abs_int} << shft_amt;

	// Hidden one above bit 17 is dropped
	assign fp_out = (int_in == '0) ? '0 :
		{int_sign, int_exp, int_shift[FRAC_W-1:0]};

	// ==============================
	// Float to integer
	// ==============================
	// 1.frac with the one at bit 18, shifted by unbiased exponent
	assign fp_shift = {{(INT_W-1){1'b0}}, 1'b1, fp_in.fields.frac} <<
		(fp_in.fields.exp - EXP_BIAS);
	assign int_mag = fp_shift[INT_W+FRAC_W-1:FRAC_W];

	always_comb begin
		if (fp_in.fields.exp < EXP_BIAS) begin
			// Magnitude below one
			int_out = '0;
		end else if (fp_in.fields.exp > EXP_BIAS + 8'(INT_W - 2)) begin
			// Past 2^14 clips to full scale
			int_out = fp_in.fields.sign ? -INT_MAX : INT_MAX;
		end else begin
			int_out = fp_in.fields.sign ? -int_mag : int_mag;
		end
	end

endmodule

//--- fp_unit.sv
`timescale 1ns/1ps

module fp_unit (
	input  logic             iCLK,
	input  logic             arst_n,
	input  logic             in_valid,
	input  fp_pkg::fp_op_e   op,
	input  fp_pkg::fp_word_u a,
	input  fp_pkg::fp_word_u b,
	output logic             out_valid,
	output fp_pkg::fp_word_u result
);
	import fp_pkg::*;

	// Datapath results
	fp_word_u                b_add;
	fp_word_u                sum;
	fp_word_u                prod;
	fp_word_u                inv_sqrt_res;
	fp_word_u                int_fp;
	fp_word_u                comb_res;
	logic signed [INT_W-1:0] int_in;
	logic signed [INT_W-1:0] fp_int;
	logic                    mag_ge;
	logic                    a_ge_b;

	// Valid and opcode shift line
	logic [UNIT_LATENCY-1:0] valid_line;
	fp_op_e                  op_line [UNIT_LATENCY-1];
	// Result words waiting for the common stage
	fp_word_u                data_line [UNIT_LATENCY-1];

	// ==============================
	// Arithmetic blocks
	// ==============================
	// Subtract flips the sign of B
	assign b_add = {b.fields.sign ^ (op == OP_SUB), b.fields.exp, b.fields.frac};

	fp_add add_inst (
		.iCLK   (iCLK),
		.arst_n (arst_n),
		.a      (a),
		.b      (b_add),
		.sum    (sum)
	);

	fp_mul mul_inst (
		.a    (a),
		.b    (b),
		.prod (prod)
	);

	fp_inv_sqrt inv_sqrt_inst (
		.iCLK     (iCLK),
		.arst_n   (arst_n),
		.a        (a),
		.inv_sqrt (inv_sqrt_res)
	);

	// Integer operand in the low half of A
	assign int_in = a.raw[INT_W-1:0];

	fp_int_convert conv_inst (
		.int_in  (int_in),
		.fp_in   (a),
		.fp_out  (int_fp),
		.int_out (fp_int)
	);

	// Compare magnitudes first, then sign cases
	assign mag_ge = (a.fields.exp > b.fields.exp) ||
		((a.fields.exp == b.fields.exp) && (a.fields.frac >= b.fields.frac));

	always_comb begin
		case ({a.fields.sign, b.fields.sign})
			2'b01:   a_ge_b = 1'b1;
			2'b10:   a_ge_b = 1'b0;
			2'b00:   a_ge_b = mag_ge;
			// Both negative reverse the order but equal words still pass
			default: a_ge_b = !mag_ge || (a.raw == b.raw);
		endcase
	end

	// Zero-cycle results, add and inv sqrt fill in later
	always_comb begin
		case (op)
			OP_MUL:       comb_res = prod;
			OP_INT_TO_FP: comb_res = int_fp;
			OP_FP_TO_INT: comb_res = {{(FP_W-INT_W){1'b0}}, fp_int};
			OP_CMP_GE:    comb_res = {{(FP_W-1){1'b0}}, a_ge_b};
			OP_ABS:       comb_res = {1'b0, a.fields.exp, a.fields.frac};
			default:      comb_res = '0;
		endcase
	end

	// ==============================
	// Delay matching
	// ==============================
	always_ff @(posedge iCLK or negedge arst_n) begin
		if (!arst_n) begin
			valid_line <= '0;
			for (int i = 0; i < UNIT_LATENCY-1; i++) begin
				op_line[i] <= OP_ADD;
			end
		end else begin
			valid_line <= {valid_line[UNIT_LATENCY-2:0], in_valid};
			op_line[0] <= op;
			for (int i = 1; i < UNIT_LATENCY-1; i++) begin
				op_line[i] <= op_line[i-1];
			end
		end
	end

	assign out_valid = valid_line[UNIT_LATENCY-1];

	// Adder sum joins the line once it is registered
	always_ff @(posedge iCLK) begin
		data_line[0] <= comb_res;
		for (int i = 1; i < UNIT_LATENCY-1; i++) begin
			if (i == ADD_LATENCY &&
				(op_line[i-1] == OP_ADD || op_line[i-1] == OP_SUB)) begin
				data_line[i] <= sum;
			end else begin
				data_line[i] <= data_line[i-1];
			end
		end
		// Inv sqrt output ready just in time
		if (op_line[UNIT_LATENCY-2] == OP_INV_SQRT) begin
			result <= inv_sqrt_res;
		end else begin
			result <= data_line[UNIT_LATENCY-2];
		end
	end

	// Quiet while reset is held
	a_no_valid_in_reset: assert property (@(posedge iCLK) !arst_n |-> !out_valid);

	// Fixed issue to result spacing
	a_fixed_latency: assert property (@(posedge iCLK) disable iff (!arst_n)
		$past(arst_n, UNIT_LATENCY) |-> out_valid == $past(in_valid, UNIT_LATENCY));

endmodule

//--- fp_checker.sv
`timescale 1ns/1ps

module fp_checker (
	input logic             iCLK,
	input logic             arst_n,
	input logic             in_valid,
	input fp_pkg::fp_op_e   op,
	input fp_pkg::fp_word_u a,
	input fp_pkg::fp_word_u b,
	input logic             out_valid,
	input fp_pkg::fp_word_u result
);
	import fp_pkg::*;

	localparam int    MAX_VECTORS      = 64;
	// Edges from the input launch edge to out_valid
	localparam int    EXPECTED_LATENCY = 6;
	localparam string GOLDEN_FILE      = "fp_golden.txt";

	logic [FP_W-1:0] exp_word [MAX_VECTORS];
	int              num_expected;
	int              value_errors;
	int              timing_errors;
	int              checked;
	int              pending;
	int              edge_count;

	// Operations in flight, oldest first
	int              issue_edge [$];
	logic [OP_W-1:0] issue_op   [$];
	logic [FP_W-1:0] issue_a    [$];
	logic [FP_W-1:0] issue_b    [$];

	// Expected column only
	initial begin
		int          fd;
		string       line;
		logic [31:0] f_op;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_exp;
		num_expected  = 0;
		value_errors  = 0;
		timing_errors = 0;
		checked       = 0;
		pending       = 0;
		edge_count    = 0;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("Checker could not open %s for expected values", GOLDEN_FILE);
		end else begin
			while (!$feof(fd) && num_expected < MAX_VECTORS) begin
				if ($fgets(line, fd) > 0) begin
					if ($sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp) == 4) begin
						exp_word[num_expected] = f_exp[FP_W-1:0];
						num_expected++;
					end
				end
			end
			$fclose(fd);
		end
	end

	always @(posedge iCLK) begin
		edge_count++;
	end

	// ==============================
	// Sampling at the falling edge
	// ==============================
	always @(negedge iCLK) begin
		if (!arst_n) begin
			if (out_valid) begin
				$display("out_valid was high during reset at %0t", $time);
				timing_errors++;
			end
		end else begin
			if (out_valid) begin
				if (issue_edge.size() == 0) begin
					$display("out_valid pulsed with no operation in flight at %0t", $time);
					timing_errors++;
				end else begin
					if (edge_count - issue_edge[0] != EXPECTED_LATENCY) begin
						$display("Result at %0t came %0d edges after issue", $time,
							edge_count - issue_edge[0]);
						timing_errors++;
					end
					if (checked >= num_expected) begin
						$display("Result at %0t has no expected value", $time);
						value_errors++;
					end else if (result.raw !== exp_word[checked]) begin
						$display("FAILED at %0t: op %0d a %h b %h expected %h got %h", $time,
							issue_op[0], issue_a[0], issue_b[0], exp_word[checked], result.raw);
						value_errors++;
					end
					checked++;
					void'(issue_edge.pop_front());
					void'(issue_op.pop_front());
					void'(issue_a.pop_front());
					void'(issue_b.pop_front());
				end
			end
			// Oldest operation overdue, its pulse never came
			if (issue_edge.size() > 0 && edge_count - issue_edge[0] > EXPECTED_LATENCY) begin
				$display("No out_valid for op %0d launched at edge %0d", issue_op[0],
					issue_edge[0]);
				timing_errors++;
				checked++;
				void'(issue_edge.pop_front());
				void'(issue_op.pop_front());
				void'(issue_a.pop_front());
				void'(issue_b.pop_front());
			end
			// Launch edge of this input, the DUT samples it at the next one
			if (in_valid) begin
				issue_edge.push_back(edge_count);
				issue_op.push_back(op);
				issue_a.push_back(a.raw);
				issue_b.push_back(b.raw);
			end
		end
		pending = issue_edge.size();
	end

endmodule

//--- tb_fp_unit.sv
`timescale 1ns/1ps

module tb_fp_unit;
	import fp_pkg::*;

	localparam int    MAX_VECTORS   = 64;
	localparam int    DRAIN_TIMEOUT = 100;
	localparam string GOLDEN_FILE   = "fp_golden.txt";

	logic     iCLK;
	logic     arst_n;
	logic     in_valid;
	fp_op_e   op;
	fp_word_u a;
	fp_word_u b;
	logic     out_valid;
	fp_word_u result;

	// Stimulus columns of the golden file
	logic [OP_W-1:0] vec_op [MAX_VECTORS];
	logic [FP_W-1:0] vec_a  [MAX_VECTORS];
	logic [FP_W-1:0] vec_b  [MAX_VECTORS];
	int              num_vectors;
	int              other_errors;
	int              drain_cycles;
	int              total_errors;

	fp_unit fp_unit_inst (
		.iCLK      (iCLK),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	fp_checker checker_inst (
		.iCLK      (iCLK),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	// 8 ns period
	always #4 iCLK = ~iCLK;

	// Opcode, A and B from each data line
	task automatic load_stimulus();
		int              fd;
		string           line;
		logic [31:0]     f_op;
		logic [31:0]     f_a;
		logic [31:0]     f_b;
		logic [31:0]     f_exp;
		num_vectors = 0;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open %s for stimulus", GOLDEN_FILE);
			other_errors++;
		end else begin
			while (!$feof(fd) && num_vectors < MAX_VECTORS) begin
				if ($fgets(line, fd) > 0) begin
					// Comment lines do not scan as four fields
					if ($sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp) == 4) begin
						vec_op[num_vectors] = f_op[OP_W-1:0];
						vec_a[num_vectors]  = f_a[FP_W-1:0];
						vec_b[num_vectors]  = f_b[FP_W-1:0];
						num_vectors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One operation, 1 ns after the edge
	task automatic issue_vector(input int idx);
		@(posedge iCLK);
		#1;
		in_valid = 1'b1;
		op       = fp_op_e'(vec_op[idx]);
		a        = vec_a[idx];
		b        = vec_b[idx];
	endtask

	task automatic idle_cycle();
		@(posedge iCLK);
		#1;
		in_valid = 1'b0;
	endtask

	initial begin
		iCLK         = 1'b0;
		arst_n       = 1'b0;
		in_valid     = 1'b0;
		op           = OP_ADD;
		a            = '0;
		b            = '0;
		other_errors = 0;
		repeat (10) @(posedge iCLK);
		#1 arst_n = 1'b1;
		load_stimulus();
		// Back to back, with two idle gaps
		for (int i = 0; i < num_vectors; i++) begin
			issue_vector(i);
			if (i == 7 || i == 15) begin
				idle_cycle();
			end
		end
		idle_cycle();
		drain_cycles = 0;
		while (checker_inst.pending > 0 && drain_cycles < DRAIN_TIMEOUT) begin
			@(posedge iCLK);
			drain_cycles++;
		end
		if (drain_cycles >= DRAIN_TIMEOUT) begin
			$display("Timed out waiting for the last results to leave the DUT");
			other_errors++;
		end
		repeat (2) @(posedge iCLK);
		if (checker_inst.checked != num_vectors || num_vectors == 0) begin
			$display("Only %0d of %0d results were checked", checker_inst.checked, num_vectors);
			other_errors++;
		end
		total_errors = checker_inst.value_errors + checker_inst.timing_errors + other_errors;
		$display("Errors: %0d value, %0d timing, %0d other", checker_inst.value_errors,
			checker_inst.timing_errors, other_errors);
		if (total_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog for the whole run
	initial begin
		#100000;
		$display("Simulation ran past its time limit");
		$display("Test failed");
		$finish;
	end

endmodule

//--- fp_golden.txt
# Columns: opcode A B expected, all hex, 27-bit words
# Opcodes: 0 add 1 sub 2 mul 3 inv sqrt 4 int to fp 5 fp to int 6 cmp ge 7 abs
0 1FE0000 2008000 2038000
1 2008000 1FE0000 1FA0000
1 1FE0000 1FE0000 0000000
0 0000000 2008000 2008000
0 1FE0000 0000000 1FE0000
0 1FC0000 29C0000 29C0000
2 1FE0000 2008000 202C000
2 5FE0000 2008000 602C000
2 5FE0000 6008000 202C000
2 1FF0000 1FF0000 2022000
2 1FC0001 1FC0000 1FC0000
2 0000000 2008000 0000000
2 0040000 1000000 0000000
3 1FC0000 0000000 1FBFC85
3 2040000 0000000 1F7FC85
3 1F40000 0000000 1FFFC85
4 0000000 0000000 0000000
4 0000001 0000000 1FC0000
4 000FFFF 0000000 5FC0000
4 0007FFF 0000000 237FFF0
4 0008000 0000000 6380000
5 1FC0000 0000000 0000001
5 5FC0000 0000000 000FFFF
5 237FFF0 0000000 0007FFF
5 6380000 0000000 0008001
5 2580000 0000000 0007FFF
5 1FA0000 0000000 0000000
5 2008000 0000000 0000002
6 2008000 1FE0000 0000001
6 1FE0000 2008000 0000000
6 5FE0000 2008000 0000000
6 1FE0000 6008000 0000001
6 5FE0000 6008000 0000001
6 1FE0000 1FE0000 0000001
7 6008000 0000000 2008000
7 5FE0000 0000000 1FE0000

//--- verilog.f
fp_pkg.sv
fp_mul.sv
fp_add.sv
fp_inv_sqrt.sv
fp_int_convert.sv
fp_unit.sv
fp_checker.sv
tb_fp_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fp_unit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
